// File: src/lsuPkg.sv
// ======================================================================
// Load/store unit shared definitions
// ======================================================================
`default_nettype none

package lsuPkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Cache geometry defaults, overridden from the top level
    localparam int DEFAULT_LINE_BYTES = 16;
    localparam int DEFAULT_INDEX_WIDTH = 6;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    typedef enum logic [1:0] {
        CmdNone,
        CmdLoad,
        CmdStore,
        CmdInvalidate
    } lsuCmd_t;

    // Unsigned variants only matter for loads
    typedef enum logic [2:0] {
        SizeByte,
        SizeHalf,
        SizeWord,
        SizeByteU,
        SizeHalfU
    } accessSize_t;

    typedef enum logic [1:0] {
        CacheNone,
        CacheInvalidate,
        CacheReplace,
        CacheWriteThrough
    } cacheCmd_t;

endpackage

`default_nettype wire

// File: src/cacheArrayIf.sv
// ======================================================================
// Controller to cache array link
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

interface cacheArrayIf #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int INDEX_WIDTH = lsuPkg::DEFAULT_INDEX_WIDTH
);
    import lsuPkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - $clog2(LINE_BYTES);

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [LINE_BYTES-1:0] byteMask_t;

    index_t index;
    logic tagWriteEnable;
    logic writeValid;
    tag_t writeTag;
    line_t writeData;
    byteMask_t writeMask;

    // Registered, one cycle after index
    logic readValid;
    tag_t readTag;
    line_t readData;

    modport controller (
        output index, tagWriteEnable, writeValid, writeTag, writeData, writeMask,
        input readValid, readTag, readData
    );

    modport arrays (
        input index, tagWriteEnable, writeValid, writeTag, writeData, writeMask,
        output readValid, readTag, readData
    );

endinterface

`default_nettype wire

// File: src/replacerIf.sv
// ======================================================================
// Controller to line replacer link
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

interface replacerIf #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int INDEX_WIDTH = lsuPkg::DEFAULT_INDEX_WIDTH
);
    import lsuPkg::*;

    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] lineAddr_t;

    // Held by the controller until done
    cacheCmd_t command;
    lineAddr_t lineAddr;
    logic arrayReadValid;
    tag_t arrayReadTag;
    line_t arrayReadData;

    logic arrayWriteEnable;
    index_t arrayIndex;
    logic arrayWriteValid;
    tag_t arrayWriteTag;
    line_t arrayWriteData;
    logic done;

    modport controller (
        output command, lineAddr, arrayReadValid, arrayReadTag, arrayReadData,
        input arrayWriteEnable, arrayIndex, arrayWriteValid, arrayWriteTag,
        input arrayWriteData, done
    );

    modport replacer (
        input command, lineAddr, arrayReadValid, arrayReadTag, arrayReadData,
        output arrayWriteEnable, arrayIndex, arrayWriteValid, arrayWriteTag,
        output arrayWriteData, done
    );

endinterface

`default_nettype wire

// File: src/dcacheArrays.sv
// ======================================================================
// Data cache valid/tag and data arrays
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module dcacheArrays #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int INDEX_WIDTH = lsuPkg::DEFAULT_INDEX_WIDTH
) (
    input logic clk,
    input logic rst,
    cacheArrayIf.arrays arr
);
    import lsuPkg::*;

    localparam int LINE_COUNT = 2 ** INDEX_WIDTH;
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - $clog2(LINE_BYTES);

    typedef logic [TAG_WIDTH-1:0] tag_t;

    logic [LINE_COUNT-1:0] validBits;
    tag_t tagMem [LINE_COUNT];

    // Valid bits live in flops so reset can clear them all at once
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            arr.readValid <= 1'b0;
        end else begin
            if (arr.tagWriteEnable) begin
                validBits[arr.index] <= arr.writeValid;
            end
            arr.readValid <= arr.tagWriteEnable ? arr.writeValid : validBits[arr.index];
        end
    end

    // Write-first read port
    always_ff @(posedge clk) begin
        if (arr.tagWriteEnable) begin
            tagMem[arr.index] <= arr.writeTag;
            arr.readTag <= arr.writeTag;
        end else begin
            arr.readTag <= tagMem[arr.index];
        end
    end

    // One byte bank per mask bit
    for (genvar b = 0; b < LINE_BYTES; b++) begin : gBank
        logic [7:0] bankMem [LINE_COUNT];
        logic [7:0] bankOut;

        always_ff @(posedge clk) begin
            if (arr.writeMask[b]) begin
                bankMem[arr.index] <= arr.writeData[8*b +: 8];
                bankOut <= arr.writeData[8*b +: 8];
            end else begin
                bankOut <= bankMem[arr.index];
            end
        end

        assign arr.readData[8*b +: 8] = bankOut;
    end

endmodule

`default_nettype wire

// File: src/dcacheReplacer.sv
// ======================================================================
// Refill, write-through and invalidate sequencer
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module dcacheReplacer #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int INDEX_WIDTH = lsuPkg::DEFAULT_INDEX_WIDTH
) (
    input logic clk,
    input logic rst,
    replacerIf.replacer rep,
    output logic [lsuPkg::ADDR_WIDTH-$clog2(LINE_BYTES)-1:0] memAddr,
    output logic memReadReq,
    input logic memReadGrant,
    input logic [LINE_BYTES*8-1:0] memReadValue,
    output logic memWriteReq,
    input logic memWriteGrant,
    output logic [LINE_BYTES*8-1:0] memWriteValue
);
    import lsuPkg::*;

    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    index_t lineIndex;
    tag_t lineTag;
    index_t clearIndex;
    logic clearDone;

    assign lineIndex = rep.lineAddr[INDEX_WIDTH-1:0];
    assign lineTag = rep.lineAddr[ADDR_WIDTH-OFFSET_WIDTH-1:INDEX_WIDTH];

    // Sweep every index, then one extra cycle to report done
    always_ff @(posedge clk) begin
        if (rst) begin
            clearIndex <= '0;
            clearDone <= 1'b0;
        end else if (rep.command == CacheInvalidate) begin
            if (clearDone) begin
                clearDone <= 1'b0;
            end else begin
                clearIndex <= clearIndex + 1'b1;
                if (clearIndex == '1) begin
                    clearDone <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        memAddr = rep.lineAddr;
        memReadReq = 1'b0;
        memWriteReq = 1'b0;
        memWriteValue = rep.arrayReadData;
        rep.arrayWriteEnable = 1'b0;
        rep.arrayIndex = lineIndex;
        rep.arrayWriteValid = 1'b0;
        rep.arrayWriteTag = lineTag;
        rep.arrayWriteData = memReadValue;
        rep.done = 1'b0;

        case (rep.command)
            CacheReplace: begin
                // Line lands in the array in the grant cycle
                memReadReq = 1'b1;
                rep.arrayWriteEnable = memReadGrant;
                rep.arrayWriteValid = 1'b1;
                rep.done = memReadGrant;
            end
            CacheWriteThrough: begin
                // Array output already holds the merged line
                memAddr = {rep.arrayReadTag, lineIndex};
                memWriteReq = rep.arrayReadValid;
                rep.done = memWriteGrant || !rep.arrayReadValid;
            end
            CacheInvalidate: begin
                rep.arrayIndex = clearIndex;
                rep.arrayWriteEnable = !clearDone;
                rep.done = clearDone;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/loadAligner.sv
// ======================================================================
// Load data alignment
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module loadAligner #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES
) (
    input logic [LINE_BYTES*8-1:0] line,
    input logic [$clog2(LINE_BYTES)-1:0] offset,
    input lsuPkg::accessSize_t accessSize,
    output lsuPkg::word_t result
);
    import lsuPkg::*;

    typedef logic [LINE_BYTES*8-1:0] line_t;

    line_t shifted;
    word_t raw;

    always_comb begin
        shifted = line >> {offset, 3'b000};
        raw = shifted[DATA_WIDTH-1:0];

        case (accessSize)
            SizeByte:  result = {{(DATA_WIDTH-8){raw[7]}}, raw[7:0]};
            SizeHalf:  result = {{(DATA_WIDTH-16){raw[15]}}, raw[15:0]};
            SizeByteU: result = {{(DATA_WIDTH-8){1'b0}}, raw[7:0]};
            SizeHalfU: result = {{(DATA_WIDTH-16){1'b0}}, raw[15:0]};
            default:   result = raw;
        endcase
    end

endmodule

`default_nettype wire

// File: src/lsuController.sv
// ======================================================================
// Load/store controller
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module lsuController #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int INDEX_WIDTH = lsuPkg::DEFAULT_INDEX_WIDTH
) (
    input logic clk,
    input logic rst,
    input logic enable,
    input lsuPkg::lsuCmd_t command,
    input lsuPkg::accessSize_t accessSize,
    input lsuPkg::word_t base,
    input lsuPkg::word_t imm,
    input lsuPkg::word_t storeValue,
    output logic done,
    output lsuPkg::addr_t resultAddr,
    output lsuPkg::word_t resultValue,
    cacheArrayIf.controller arrays,
    replacerIf.controller rep
);
    import lsuPkg::*;

    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [LINE_BYTES-1:0] byteMask_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

    typedef enum logic [2:0] {
        Idle,
        Load,
        Store,
        WriteThrough,
        Replace,
        Invalidate
    } state_t;

    function automatic byteMask_t makeMask(accessSize_t size, offset_t offset);
        byteMask_t mask;
        case (size)
            SizeByte, SizeByteU: mask = byteMask_t'(1'b1);
            SizeHalf, SizeHalfU: mask = byteMask_t'(2'b11);
            default:             mask = byteMask_t'(4'b1111);
        endcase
        return mask << offset;
    endfunction

    state_t state;
    state_t nextState;
    addr_t addrReg;
    word_t storeReg;
    accessSize_t sizeReg;

    addr_t nextAddr;
    offset_t offset;
    index_t regIndex;
    tag_t regTag;
    logic hit;
    line_t storeLine;

    assign nextAddr = base + imm;
    assign offset = addrReg[OFFSET_WIDTH-1:0];
    assign regIndex = addrReg[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH];
    assign regTag = addrReg[ADDR_WIDTH-1:OFFSET_WIDTH+INDEX_WIDTH];

    // Read outputs belong to the request registered in Idle
    assign hit = arrays.readValid && (arrays.readTag == regTag);
    assign storeLine = line_t'(storeReg) << {offset, 3'b000};

    // In WriteThrough the line is already merged, so this reads back the store
    loadAligner #(
        .LINE_BYTES(LINE_BYTES)
    ) i_loadAligner (
        .line(arrays.readData),
        .offset(offset),
        .accessSize(sizeReg),
        .result(resultValue)
    );

    assign resultAddr = addrReg;
    assign done = (state == Load && hit) ||
                  ((state == WriteThrough || state == Invalidate) && rep.done);

    assign rep.lineAddr = addrReg[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign rep.arrayReadValid = arrays.readValid;
    assign rep.arrayReadTag = arrays.readTag;
    assign rep.arrayReadData = arrays.readData;

    always_comb begin
        case (state)
            Replace:      rep.command = CacheReplace;
            WriteThrough: rep.command = CacheWriteThrough;
            Invalidate:   rep.command = CacheInvalidate;
            default:      rep.command = CacheNone;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (enable) begin
                    case (command)
                        CmdLoad:       nextState = Load;
                        CmdStore:      nextState = Store;
                        CmdInvalidate: nextState = Invalidate;
                        default:       nextState = Idle;
                    endcase
                end
            end
            Load:  nextState = hit ? Idle : Replace;
            Store: nextState = hit ? WriteThrough : Replace;
            default: begin
                if (rep.done) begin
                    nextState = Idle;
                end
            end
        endcase
    end

    // Replacer owns the arrays while it sequences
    always_comb begin
        arrays.index = (state == Idle) ?
            nextAddr[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH] : regIndex;
        arrays.tagWriteEnable = 1'b0;
        arrays.writeValid = 1'b0;
        arrays.writeTag = regTag;
        arrays.writeData = storeLine;
        arrays.writeMask = '0;

        if (state == Replace || state == Invalidate) begin
            arrays.index = rep.arrayIndex;
            arrays.tagWriteEnable = rep.arrayWriteEnable;
            arrays.writeValid = rep.arrayWriteValid;
            arrays.writeTag = rep.arrayWriteTag;
            arrays.writeData = rep.arrayWriteData;
            if (state == Replace && rep.arrayWriteEnable) begin
                arrays.writeMask = '1;
            end
        end else if (state == Store && hit) begin
            arrays.writeMask = makeMask(sizeReg, offset);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle) begin
            addrReg <= nextAddr;
            storeReg <= storeValue;
            sizeReg <= accessSize;
        end
    end

endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
// ======================================================================
// Load/store unit with write-through data cache
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module loadStoreUnit #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int INDEX_WIDTH = lsuPkg::DEFAULT_INDEX_WIDTH
) (
    input logic clk,
    input logic rst,
    input logic enable,
    input lsuPkg::lsuCmd_t command,
    input lsuPkg::accessSize_t accessSize,
    input lsuPkg::word_t base,
    input lsuPkg::word_t imm,
    input lsuPkg::word_t storeValue,
    output logic done,
    output lsuPkg::addr_t resultAddr,
    output lsuPkg::word_t resultValue,
    output logic [lsuPkg::ADDR_WIDTH-$clog2(LINE_BYTES)-1:0] memAddr,
    output logic memReadReq,
    input logic memReadGrant,
    input logic [LINE_BYTES*8-1:0] memReadValue,
    output logic memWriteReq,
    input logic memWriteGrant,
    output logic [LINE_BYTES*8-1:0] memWriteValue
);

    cacheArrayIf #(.LINE_BYTES(LINE_BYTES), .INDEX_WIDTH(INDEX_WIDTH)) arrayBus ();
    replacerIf #(.LINE_BYTES(LINE_BYTES), .INDEX_WIDTH(INDEX_WIDTH)) repBus ();

    lsuController #(
        .LINE_BYTES(LINE_BYTES),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) i_lsuController (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .command(command),
        .accessSize(accessSize),
        .base(base),
        .imm(imm),
        .storeValue(storeValue),
        .done(done),
        .resultAddr(resultAddr),
        .resultValue(resultValue),
        .arrays(arrayBus.controller),
        .rep(repBus.controller)
    );

    dcacheArrays #(
        .LINE_BYTES(LINE_BYTES),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) i_dcacheArrays (
        .clk(clk),
        .rst(rst),
        .arr(arrayBus.arrays)
    );

    dcacheReplacer #(
        .LINE_BYTES(LINE_BYTES),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) i_dcacheReplacer (
        .clk(clk),
        .rst(rst),
        .rep(repBus.replacer),
        .memAddr(memAddr),
        .memReadReq(memReadReq),
        .memReadGrant(memReadGrant),
        .memReadValue(memReadValue),
        .memWriteReq(memWriteReq),
        .memWriteGrant(memWriteGrant),
        .memWriteValue(memWriteValue)
    );

endmodule

`default_nettype wire

// File: bench/memoryModel.sv
// ======================================================================
// Line-wide backing memory with random grant delay
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module memoryModel #(
    parameter int LINE_BYTES = lsuPkg::DEFAULT_LINE_BYTES,
    parameter int MEM_LINES = 64,
    parameter int MAX_DELAY = 5
) (
    input logic clk,
    input logic rst,
    input logic [lsuPkg::ADDR_WIDTH-$clog2(LINE_BYTES)-1:0] memAddr,
    input logic memReadReq,
    output logic memReadGrant,
    output logic [LINE_BYTES*8-1:0] memReadValue,
    input logic memWriteReq,
    output logic memWriteGrant,
    input logic [LINE_BYTES*8-1:0] memWriteValue
);
    import lsuPkg::*;

    localparam int SLOT_WIDTH = $clog2(MEM_LINES);

    typedef logic [LINE_BYTES*8-1:0] line_t;

    // Loaded by the testbench before reset ends
    line_t lines [MEM_LINES];
    logic pending;
    int waitLeft;
    int delay;
    logic [SLOT_WIDTH-1:0] slot;

    assign slot = memAddr[SLOT_WIDTH-1:0];

    initial begin
        memReadGrant = 1'b0;
        memWriteGrant = 1'b0;
        memReadValue = '0;
        pending = 1'b0;
        waitLeft = 0;
    end

    // Grants move on the falling edge, away from the DUT's clock edge
    always @(negedge clk) begin
        memReadGrant <= 1'b0;
        memWriteGrant <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
        end else if ((memReadReq || memWriteReq) && !memReadGrant && !memWriteGrant) begin
            delay = pending ? waitLeft : $urandom_range(0, MAX_DELAY);
            if (delay == 0) begin
                pending <= 1'b0;
                if (memReadReq) begin
                    memReadValue <= lines[slot];
                    memReadGrant <= 1'b1;
                end else begin
                    lines[slot] <= memWriteValue;
                    memWriteGrant <= 1'b1;
                end
            end else begin
                pending <= 1'b1;
                waitLeft <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/lsuTb.sv
// ======================================================================
// Load/store unit testbench
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module lsuTb;
    import lsuPkg::*;

    localparam int LINE_BYTES = 16;
    localparam int INDEX_WIDTH = 4;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int MEM_LINES = 64;
    localparam int MEM_BYTES = MEM_LINES * LINE_BYTES;
    localparam int TIMEOUT_CYCLES = 200;
    localparam addr_t WINDOW_BASE = 32'h0000_8000;

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] lineAddr_t;

    logic clk;
    logic rst;
    logic enable;
    lsuCmd_t command;
    accessSize_t accessSize;
    word_t base;
    word_t imm;
    word_t storeValue;
    logic done;
    addr_t resultAddr;
    word_t resultValue;
    lineAddr_t memAddr;
    logic memReadReq;
    logic memReadGrant;
    line_t memReadValue;
    logic memWriteReq;
    logic memWriteGrant;
    line_t memWriteValue;

    // Byte-wide reference copy of the memory window
    logic [7:0] refMem [MEM_BYTES];
    int errorCount;
    int checkCount;
    int testCount;
    int testErrors;
    int testChecks;
    int readCount;
    int writeCount;
    lineAddr_t lastReadAddr;
    lineAddr_t lastWriteAddr;
    line_t lastWriteLine;
    word_t gotValue;
    addr_t gotAddr;

    loadStoreUnit #(
        .LINE_BYTES(LINE_BYTES),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) i_loadStoreUnit (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .command(command),
        .accessSize(accessSize),
        .base(base),
        .imm(imm),
        .storeValue(storeValue),
        .done(done),
        .resultAddr(resultAddr),
        .resultValue(resultValue),
        .memAddr(memAddr),
        .memReadReq(memReadReq),
        .memReadGrant(memReadGrant),
        .memReadValue(memReadValue),
        .memWriteReq(memWriteReq),
        .memWriteGrant(memWriteGrant),
        .memWriteValue(memWriteValue)
    );

    memoryModel #(
        .LINE_BYTES(LINE_BYTES),
        .MEM_LINES(MEM_LINES)
    ) i_memoryModel (
        .clk(clk),
        .rst(rst),
        .memAddr(memAddr),
        .memReadReq(memReadReq),
        .memReadGrant(memReadGrant),
        .memReadValue(memReadValue),
        .memWriteReq(memWriteReq),
        .memWriteGrant(memWriteGrant),
        .memWriteValue(memWriteValue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [7:0] fillByte(addr_t addr);
        addr_t product;
        product = addr * 32'h9E37_79B1;
        return product[31:24];
    endfunction

    function automatic int sizeBytes(accessSize_t size);
        case (size)
            SizeByte, SizeByteU: return 1;
            SizeHalf, SizeHalfU: return 2;
            default:             return 4;
        endcase
    endfunction

    function automatic line_t refLine(int lineSlot);
        line_t value;
        for (int b = 0; b < LINE_BYTES; b++) begin
            value[8*b +: 8] = refMem[lineSlot * LINE_BYTES + b];
        end
        return value;
    endfunction

    function automatic word_t expectedLoad(addr_t addr, accessSize_t size);
        int pos;
        word_t raw;
        pos = int'(addr - WINDOW_BASE);
        raw = '0;
        for (int b = 0; b < sizeBytes(size); b++) begin
            raw[8*b +: 8] = refMem[pos + b];
        end
        case (size)
            SizeByte: return {{24{raw[7]}}, raw[7:0]};
            SizeHalf: return {{16{raw[15]}}, raw[15:0]};
            default:  return raw;
        endcase
    endfunction

    function automatic word_t randomImm();
        return word_t'($urandom_range(0, 127)) - 32'd64;
    endfunction

    task automatic reportFailure(input string what);
        $display("%0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic checkEqual(input string signal, input line_t expected, input line_t actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected %0h got %0h",
                     $time, signal, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkIdleOutputs();
        checkEqual("done", 1'b0, done);
        checkEqual("memReadReq", 1'b0, memReadReq);
        checkEqual("memWriteReq", 1'b0, memWriteReq);
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %-22s %0d checks, %0d errors", name,
                 checkCount - testChecks, errorCount - testErrors);
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic waitForDone(output int cycles);
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
                gotValue = resultValue;
                gotAddr = resultAddr;
            end
        end
        if (!seen) begin
            $display("%0t: timed out waiting for done", $time);
            $display("*** FAILED ***");
            $finish;
        end
    endtask

    task automatic runRequest(input lsuCmd_t cmd, input accessSize_t size, input word_t baseValue,
                              input word_t immValue, input word_t value, output int cycles);
        @(negedge clk);
        enable = 1'b1;
        command = cmd;
        accessSize = size;
        base = baseValue;
        imm = immValue;
        storeValue = value;
        waitForDone(cycles);
        @(negedge clk);
        enable = 1'b0;
        command = CmdNone;
        // done must be a single-cycle pulse
        checkEqual("done", 1'b0, done);
    endtask

    task automatic loadAndCheck(input addr_t addr, input accessSize_t size, output int cycles);
        word_t immValue;
        immValue = randomImm();
        runRequest(CmdLoad, size, addr - immValue, immValue, '0, cycles);
        checkEqual("resultValue", expectedLoad(addr, size), gotValue);
        checkEqual("resultAddr", addr, gotAddr);
    endtask

    task automatic storeAndCheck(input addr_t addr, input accessSize_t size, input word_t value);
        int writesBefore;
        int cycles;
        int pos;
        word_t immValue;
        writesBefore = writeCount;
        immValue = randomImm();
        pos = int'(addr - WINDOW_BASE);
        runRequest(CmdStore, size, addr - immValue, immValue, value, cycles);
        for (int b = 0; b < sizeBytes(size); b++) begin
            refMem[pos + b] = value[8*b +: 8];
        end
        checkEqual("memWrite count", writesBefore + 1, writeCount);
        checkEqual("memWriteValue", refLine(pos / LINE_BYTES), lastWriteLine);
        checkEqual("memAddr", addr >> OFFSET_WIDTH, lastWriteAddr);
        checkEqual("resultAddr", addr, gotAddr);
    endtask

    // Memory traffic monitor
    always @(posedge clk) begin
        if (!rst) begin
            assert (!(memReadReq && memWriteReq)) else
                reportFailure("read and write requested in the same cycle");
            if (memReadReq && memReadGrant) begin
                readCount <= readCount + 1;
                lastReadAddr <= memAddr;
            end
            if (memWriteReq && memWriteGrant) begin
                writeCount <= writeCount + 1;
                lastWriteAddr <= memAddr;
                lastWriteLine <= memWriteValue;
            end
            if ((memReadReq && memReadGrant) || (memWriteReq && memWriteGrant)) begin
                assert ((memAddr >> $clog2(MEM_LINES)) ==
                        (WINDOW_BASE >> (OFFSET_WIDTH + $clog2(MEM_LINES)))) else
                    reportFailure("memory access outside the test window");
            end
        end
    end

    initial begin
        int unsigned seed;
        int cycles;
        int readsBefore;
        int writesBefore;
        int k;
        int width;
        addr_t addr;
        accessSize_t size;

        seed = 68410;
        void'($urandom(seed));
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        testErrors = 0;
        testChecks = 0;
        readCount = 0;
        writeCount = 0;
        lastReadAddr = '0;
        lastWriteAddr = '0;
        lastWriteLine = '0;
        rst = 1'b1;
        enable = 1'b0;
        command = CmdNone;
        accessSize = SizeWord;
        base = '0;
        imm = '0;
        storeValue = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            refMem[i] = fillByte(WINDOW_BASE + i);
        end
        for (int l = 0; l < MEM_LINES; l++) begin
            i_memoryModel.lines[l] = refLine(l);
        end

        // Reset spans five rising edges
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            checkIdleOutputs();
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        checkIdleOutputs();
        @(negedge clk);
        checkIdleOutputs();
        endTest("reset state");

        readsBefore = readCount;
        loadAndCheck(WINDOW_BASE + 32'h42, SizeHalf, cycles);
        checkEqual("memRead count", readsBefore + 1, readCount);
        checkEqual("memAddr", (WINDOW_BASE + 32'h40) >> OFFSET_WIDTH, lastReadAddr);
        loadAndCheck(WINDOW_BASE + 32'h48, SizeByteU, cycles);
        checkEqual("memRead count", readsBefore + 1, readCount);
        checkEqual("load hit cycles", 2, cycles);
        endTest("load after reset");

        storeAndCheck(WINDOW_BASE + 32'h50, SizeWord, $urandom());
        loadAndCheck(WINDOW_BASE + 32'h50, SizeWord, cycles);
        storeAndCheck(WINDOW_BASE + 32'h56, SizeHalf, $urandom());
        loadAndCheck(WINDOW_BASE + 32'h56, SizeHalf, cycles);
        storeAndCheck(WINDOW_BASE + 32'h59, SizeByte, $urandom());
        loadAndCheck(WINDOW_BASE + 32'h59, SizeByte, cycles);
        endTest("store width and merge");

        // Lines 0 and 16 share index 0, lines 1 and 17 share index 1
        for (int n = 0; n < 200; n++) begin
            k = $urandom_range(0, 3);
            size = accessSize_t'($urandom_range(0, 4));
            width = sizeBytes(size);
            addr = WINDOW_BASE + (((k & 2) != 0) ? 256 : 0) + (k & 1) * LINE_BYTES +
                   $urandom_range(0, LINE_BYTES / width - 1) * width;
            if ($urandom_range(0, 1) == 1) begin
                storeAndCheck(addr, size, $urandom());
            end else begin
                loadAndCheck(addr, size, cycles);
            end
        end
        for (int l = 0; l < MEM_LINES; l++) begin
            checkEqual($sformatf("memory line %0d", l), refLine(l), i_memoryModel.lines[l]);
        end
        endTest("random mix");

        readsBefore = readCount;
        loadAndCheck(WINDOW_BASE + 32'h44, SizeWord, cycles);
        checkEqual("memRead count", readsBefore, readCount);
        writesBefore = writeCount;
        runRequest(CmdInvalidate, SizeWord, WINDOW_BASE, '0, '0, cycles);
        checkEqual("invalidate cycles", (1 << INDEX_WIDTH) + 2, cycles);
        checkEqual("memRead count", readsBefore, readCount);
        checkEqual("memWrite count", writesBefore, writeCount);
        loadAndCheck(WINDOW_BASE + 32'h44, SizeWord, cycles);
        checkEqual("memRead count", readsBefore + 1, readCount);
        loadAndCheck(WINDOW_BASE + 32'h118, SizeHalfU, cycles);
        checkEqual("memRead count", readsBefore + 2, readCount);
        endTest("invalidate");

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu.f
src/lsuPkg.sv
src/cacheArrayIf.sv
src/replacerIf.sv
src/dcacheArrays.sv
src/dcacheReplacer.sv
src/loadAligner.sv
src/lsuController.sv
src/loadStoreUnit.sv
bench/memoryModel.sv
bench/lsuTb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - src/lsuPkg.sv
  - src/cacheArrayIf.sv
  - src/replacerIf.sv
  - src/dcacheArrays.sv
  - src/dcacheReplacer.sv
  - src/loadAligner.sv
  - src/lsuController.sv
  - src/loadStoreUnit.sv
  - target: test
    files:
      - bench/memoryModel.sv
      - bench/lsuTb.sv
